/* all.f */
+incdir+tests
common/fix_msg_pkg.sv
common/fix_tag_pkg.sv
common/fix_field_if.sv
hw/msg_builder/field_sequencer.sv
hw/msg_builder/field_encoder.sv
hw/msg_builder/fix_msg_builder.sv
tests/tb_fix_msg_builder.sv

/* Bender.yml */
package:
  name: fix_msg_builder

sources:
  - common/fix_msg_pkg.sv
  - common/fix_tag_pkg.sv
  - common/fix_field_if.sv
  - hw/msg_builder/field_sequencer.sv
  - hw/msg_builder/field_encoder.sv
  - hw/msg_builder/fix_msg_builder.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_fix_msg_builder.sv

/* tests/fix_msg_model.svh */
// Reference model for the FIX message builder testbench.
// build_expected() queues the items that one message should produce,
// the compare tasks check one DUT item against a queued one.
`ifndef FIX_MSG_MODEL_SVH
`define FIX_MSG_MODEL_SVH

typedef struct {
	logic      is_value;
	// checksum_o for a tag item, start_chksm_o for a value item
	logic      flag;
	field_id_t fid;
	tag_t      tag;
	tag_len_t  tag_len;
	value_t    val;
	val_len_t  val_len;
} exp_item_t;

exp_item_t exp_q[$];
int        err_cnt = 0;

function automatic exp_item_t tag_item(field_id_t fid, tag_t tag, tag_len_t len);
	exp_item_t it;
	it = '{1'b0, fid == FLD_CHECKSUM, fid, tag, len, '0, '0};
	return it;
endfunction

function automatic exp_item_t val_item(field_id_t fid, value_t val, val_len_t len);
	exp_item_t it;
	it = '{1'b1, fid == FLD_BEGIN_STRING, fid, '0, '0, val, len};
	return it;
endfunction

// header fields, the two logon fields, then the CheckSum tag on its own
function automatic void build_expected(msg_type_t t);
	value_t mt;
	case (t)
		MSG_LOGON:     mt = MSGTYPE_LOGON_VAL;
		MSG_HEARTBEAT: mt = MSGTYPE_HEARTBEAT_VAL;
		default:       mt = MSGTYPE_LOGOUT_VAL;
	endcase
	exp_q.push_back(tag_item(FLD_BEGIN_STRING, TAG_BEGIN_STRING, TAG_LEN_BEGIN_STRING));
	exp_q.push_back(val_item(FLD_BEGIN_STRING, BEGIN_STRING_VAL, BEGIN_STRING_LEN));
	exp_q.push_back(tag_item(FLD_BODY_LENGTH, TAG_BODY_LENGTH, TAG_LEN_BODY_LENGTH));
	exp_q.push_back(val_item(FLD_BODY_LENGTH, body_len_i, body_len_len_i));
	exp_q.push_back(tag_item(FLD_MSG_TYPE, TAG_MSG_TYPE, TAG_LEN_MSG_TYPE));
	exp_q.push_back(val_item(FLD_MSG_TYPE, mt, MSGTYPE_LEN));
	exp_q.push_back(tag_item(FLD_MSG_SEQ_NUM, TAG_MSG_SEQ_NUM, TAG_LEN_MSG_SEQ_NUM));
	exp_q.push_back(val_item(FLD_MSG_SEQ_NUM, seq_num_i, seq_num_len_i));
	exp_q.push_back(tag_item(FLD_SENDER_COMP_ID, TAG_SENDER_COMP_ID, TAG_LEN_SENDER_COMP_ID));
	exp_q.push_back(val_item(FLD_SENDER_COMP_ID, sender_comp_id_i, sender_comp_id_len_i));
	exp_q.push_back(tag_item(FLD_SENDING_TIME, TAG_SENDING_TIME, TAG_LEN_SENDING_TIME));
	exp_q.push_back(val_item(FLD_SENDING_TIME, send_time_i, send_time_len_i));
	exp_q.push_back(tag_item(FLD_TARGET_COMP_ID, TAG_TARGET_COMP_ID, TAG_LEN_TARGET_COMP_ID));
	exp_q.push_back(val_item(FLD_TARGET_COMP_ID, target_comp_id_i, target_comp_id_len_i));
	if (t == MSG_LOGON) begin
		exp_q.push_back(tag_item(FLD_ENCRYPT_METHOD, TAG_ENCRYPT_METHOD, TAG_LEN_ENCRYPT_METHOD));
		exp_q.push_back(val_item(FLD_ENCRYPT_METHOD, ENCRYPT_METHOD_VAL, ENCRYPT_METHOD_LEN));
		exp_q.push_back(tag_item(FLD_HEARTBT_INT, TAG_HEARTBT_INT, TAG_LEN_HEARTBT_INT));
		exp_q.push_back(val_item(FLD_HEARTBT_INT, heartbeat_int_i, heartbeat_int_len_i));
	end
	exp_q.push_back(tag_item(FLD_CHECKSUM, TAG_CHECKSUM, TAG_LEN_CHECKSUM));
endfunction

task automatic check_tag(input field_id_t fid, input tag_t exp_tag, input tag_len_t exp_len,
		input tag_t got_tag, input tag_len_t got_len);
	if (got_tag !== exp_tag || got_len !== exp_len) begin
		err_cnt++;
		$display("mismatch at %0t: %s tag is %h len %0d, expected %h len %0d",
			$time, fid.name(), got_tag, got_len, exp_tag, exp_len);
	end
endtask

task automatic check_value(input field_id_t fid, input value_t exp_val, input val_len_t exp_len,
		input value_t got_val, input val_len_t got_len);
	if (got_val !== exp_val || got_len !== exp_len) begin
		err_cnt++;
		$display("mismatch at %0t: %s value is %h len %0d, expected %h len %0d",
			$time, fid.name(), got_val, got_len, exp_val, exp_len);
	end
endtask

task automatic expect_level(input string what, input logic exp_bit, input logic got_bit);
	if (got_bit !== exp_bit) begin
		err_cnt++;
		$display("mismatch at %0t: %s is %b, expected %b", $time, what, got_bit, exp_bit);
	end
endtask

`endif

/* tests/tb_fix_msg_builder.sv */
// Testbench for the FIX message builder.
// A serializer model acknowledges each item after a random delay, and a
// check process compares every strobe with the reference item list.

module tb_fix_msg_builder;
	timeunit 1ns;
	timeprecision 1ps;
	import fix_msg_pkg::*;
	import fix_tag_pkg::*;

	// 28 messages of up to 19 items at no more than 16 cycles per item with fifo stalls
	localparam int MSG_COUNT      = 28;
	localparam int TIMEOUT_CYCLES = MSG_COUNT * 19 * 16 + 2000;

	logic      clk = 1'b0;
	logic      rst = 1'b1;
	logic      fifo_full_i = 1'b0;
	logic      start_i, done_i, end_i, bodylen_ready_i, seq_ready_i;
	msg_type_t msg_type_i;
	value_t    body_len_i, seq_num_i, sender_comp_id_i;
	value_t    target_comp_id_i, send_time_i, heartbeat_int_i;
	val_len_t  body_len_len_i, seq_num_len_i, sender_comp_id_len_i;
	val_len_t  target_comp_id_len_i, send_time_len_i, heartbeat_int_len_i;
	tag_t      tag_o;
	tag_len_t  tag_len_o;
	value_t    val_o;
	val_len_t  val_len_o;
	logic      tag_valid_o, val_valid_o, checksum_o, start_chksm_o, msg_done_o;
	// levels at the edge where the current strobe was requested
	logic      end_q = 1'b0;
	logic      full_q = 1'b0;
	logic      bl_rdy_q = 1'b1;
	logic      seq_rdy_q = 1'b1;
	logic      ff_random = 1'b0;
	int        pass_cnt, fail_cnt, test_no, err_base;

	`include "fix_msg_model.svh"

	fix_msg_builder u_fix_msg_builder (.*);

	initial begin
		forever #2 clk = ~clk;
	end

	initial begin
		int cyc;
		cyc = 0;
		while (cyc < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cyc++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Verification failed");
		$finish;
	end

	// random fifo full pulses in about one cycle of four
	always @(negedge clk) begin
		fifo_full_i = ff_random && ($urandom_range(3, 0) == 0);
	end

	// serializer model that answers the CheckSum tag with end_i
	always begin
		int unsigned delay;
		logic        last;
		@(posedge clk);
		if (!rst && (tag_valid_o || val_valid_o)) begin
			delay = $urandom_range(6, 1);
			last  = tag_valid_o && checksum_o;
			repeat (delay - 1) @(posedge clk);
			@(negedge clk);
			if (last) begin
				end_i = 1'b1;
			end else begin
				done_i = 1'b1;
			end
			@(negedge clk);
			done_i = 1'b0;
			end_i  = 1'b0;
		end
	end

	always @(posedge clk) begin
		exp_item_t it;
		if (!rst) begin
			expect_level("msg_done_o one cycle after end_i", end_q, msg_done_o);
			if (!tag_valid_o) expect_level("checksum_o without a tag", 1'b0, checksum_o);
			if (!val_valid_o) expect_level("start_chksm_o without a value", 1'b0, start_chksm_o);
			if (tag_valid_o && val_valid_o) begin
				note_failure("tag and value strobes came in the same cycle");
			end else if (tag_valid_o || val_valid_o) begin
				if (full_q) note_failure("a strobe began while fifo_full_i was high");
				if (exp_q.size() == 0) begin
					note_failure("a strobe came when no item was expected");
				end else begin
					it = exp_q.pop_front();
					if (it.is_value !== val_valid_o) begin
						note_failure($sformatf("%s came as the wrong kind of item", it.fid.name()));
					end else if (val_valid_o) begin
						check_value(it.fid, it.val, it.val_len, val_o, val_len_o);
						expect_level("start_chksm_o", it.flag, start_chksm_o);
						if ((it.fid == FLD_BODY_LENGTH && !bl_rdy_q) ||
							(it.fid == FLD_MSG_SEQ_NUM && !seq_rdy_q)) begin
							note_failure($sformatf("%s went out before it was ready",
								it.fid.name()));
						end
					end else begin
						check_tag(it.fid, it.tag, it.tag_len, tag_o, tag_len_o);
						expect_level("checksum_o", it.flag, checksum_o);
					end
				end
			end
		end
		end_q     = end_i;
		full_q    = fifo_full_i;
		bl_rdy_q  = bodylen_ready_i;
		seq_rdy_q = seq_ready_i;
	end

	task automatic note_failure(input string msg);
		err_cnt++;
		$display("error at %0t: %s", $time, msg);
	endtask

	// left-aligned ASCII digits with zero padding
	task automatic random_value(output value_t v, output val_len_t len);
		len = val_len_t'($urandom_range(VALUE_BYTES, 1));
		v   = '0;
		for (int i = 0; i < int'(len); i++) begin
			v[VALUE_W-1-8*i -: 8] = 8'h30 + 8'($urandom_range(9, 0));
		end
	endtask

	task automatic random_inputs();
		random_value(body_len_i, body_len_len_i);
		random_value(seq_num_i, seq_num_len_i);
		random_value(sender_comp_id_i, sender_comp_id_len_i);
		random_value(target_comp_id_i, target_comp_id_len_i);
		random_value(send_time_i, send_time_len_i);
		random_value(heartbeat_int_i, heartbeat_int_len_i);
	endtask

	function automatic msg_type_t random_type();
		case ($urandom_range(2, 0))
			0:       return MSG_LOGON;
			1:       return MSG_HEARTBEAT;
			default: return MSG_LOGOUT;
		endcase
	endfunction

	// start is held until an edge with room in the fifo takes it
	task automatic start_message(input msg_type_t t, input bit check_latency);
		@(negedge clk);
		random_inputs();
		msg_type_i = t;
		start_i    = 1'b1;
		build_expected(t);
		@(posedge clk);
		while (fifo_full_i) @(posedge clk);
		@(negedge clk);
		start_i = 1'b0;
		if (check_latency) begin
			@(posedge clk);
			expect_level("tag_valid_o one cycle after start", 1'b0, tag_valid_o);
			@(posedge clk);
			expect_level("tag_valid_o two cycles after start", 1'b1, tag_valid_o);
		end
	endtask

	task automatic finish_message();
		@(posedge clk);
		while (msg_done_o !== 1'b1) @(posedge clk);
		if (exp_q.size() != 0) begin
			note_failure($sformatf("%0d expected items never appeared", exp_q.size()));
			exp_q.delete();
		end
	endtask

	task automatic close_test(input string name);
		test_no++;
		if (err_cnt == err_base) begin
			pass_cnt++;
			$display("test %0d %s: ok", test_no, name);
		end else begin
			fail_cnt++;
			$display("test %0d %s: %0d errors", test_no, name, err_cnt - err_base);
		end
		err_base = err_cnt;
	endtask

	initial begin
		void'($urandom(32'hbfa1));
		start_i         = 1'b0;
		done_i          = 1'b0;
		end_i           = 1'b0;
		bodylen_ready_i = 1'b1;
		seq_ready_i     = 1'b1;
		msg_type_i      = MSG_LOGON;
		random_inputs();
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// idle after reset and then one Logon
		repeat (8) @(posedge clk);
		start_message(MSG_LOGON, 1'b1);
		finish_message();
		close_test("logon");

		start_message(MSG_HEARTBEAT, 1'b0);
		finish_message();
		start_message(MSG_LOGOUT, 1'b0);
		finish_message();
		// code 3 is no message type
		@(negedge clk);
		msg_type_i = msg_type_t'(4'd3);
		start_i    = 1'b1;
		@(negedge clk);
		start_i = 1'b0;
		repeat (20) @(posedge clk);
		close_test("heartbeat, logout and invalid type");

		// both gated values are requested well before their levels rise
		@(negedge clk);
		bodylen_ready_i = 1'b0;
		seq_ready_i     = 1'b0;
		start_message(random_type(), 1'b0);
		repeat ($urandom_range(60, 30)) @(negedge clk);
		bodylen_ready_i = 1'b1;
		repeat ($urandom_range(70, 40)) @(negedge clk);
		seq_ready_i = 1'b1;
		finish_message();
		close_test("gated values");

		ff_random = 1'b1;
		repeat (2) begin
			start_message(random_type(), 1'b0);
			finish_message();
		end
		close_test("fifo back-pressure");

		ff_random = 1'b0;
		repeat (2) begin
			start_message(random_type(), 1'b0);
			finish_message();
		end
		close_test("start right after msg_done_o");

		ff_random = 1'b1;
		repeat (20) begin
			start_message(random_type(), 1'b0);
			finish_message();
		end
		close_test("random messages");

		$display("tests ok %0d, tests with errors %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* hw/msg_builder/fix_msg_builder.sv */
// FIX session message builder, top level.
// Streams Logon, Heartbeat or Logout messages as tag/value items to a
// serializer, one item per done_i acknowledge, closing on end_i.

module fix_msg_builder (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start_i,
	input  fix_msg_pkg::msg_type_t msg_type_i,
	input  logic                   done_i,
	input  logic                   end_i,
	input  logic                   fifo_full_i,
	input  logic                   bodylen_ready_i,
	input  logic                   seq_ready_i,
	input  fix_msg_pkg::value_t    body_len_i,
	input  fix_msg_pkg::val_len_t  body_len_len_i,
	input  fix_msg_pkg::value_t    seq_num_i,
	input  fix_msg_pkg::val_len_t  seq_num_len_i,
	input  fix_msg_pkg::value_t    sender_comp_id_i,
	input  fix_msg_pkg::val_len_t  sender_comp_id_len_i,
	input  fix_msg_pkg::value_t    target_comp_id_i,
	input  fix_msg_pkg::val_len_t  target_comp_id_len_i,
	input  fix_msg_pkg::value_t    send_time_i,
	input  fix_msg_pkg::val_len_t  send_time_len_i,
	input  fix_msg_pkg::value_t    heartbeat_int_i,
	input  fix_msg_pkg::val_len_t  heartbeat_int_len_i,
	output fix_tag_pkg::tag_t      tag_o,
	output fix_tag_pkg::tag_len_t  tag_len_o,
	output logic                   tag_valid_o,
	output fix_msg_pkg::value_t    val_o,
	output fix_msg_pkg::val_len_t  val_len_o,
	output logic                   val_valid_o,
	output logic                   checksum_o,
	output logic                   start_chksm_o,
	output logic                   msg_done_o
);

	fix_field_if u_field_if ();

	// walks the field list and handles the handshakes
	field_sequencer u_field_sequencer (
		.clk         (clk),
		.rst         (rst),
		.start_i     (start_i),
		.msg_type_i  (msg_type_i),
		.done_i      (done_i),
		.end_i       (end_i),
		.fifo_full_i (fifo_full_i),
		.fld         (u_field_if.sequencer),
		.msg_done_o  (msg_done_o)
	);

	// turns each request into a registered tag or value
	field_encoder u_field_encoder (
		.clk                  (clk),
		.rst                  (rst),
		.fld                  (u_field_if.encoder),
		.bodylen_ready_i      (bodylen_ready_i),
		.seq_ready_i          (seq_ready_i),
		.body_len_i           (body_len_i),
		.body_len_len_i       (body_len_len_i),
		.seq_num_i            (seq_num_i),
		.seq_num_len_i        (seq_num_len_i),
		.sender_comp_id_i     (sender_comp_id_i),
		.sender_comp_id_len_i (sender_comp_id_len_i),
		.target_comp_id_i     (target_comp_id_i),
		.target_comp_id_len_i (target_comp_id_len_i),
		.send_time_i          (send_time_i),
		.send_time_len_i      (send_time_len_i),
		.heartbeat_int_i      (heartbeat_int_i),
		.heartbeat_int_len_i  (heartbeat_int_len_i),
		.tag_o                (tag_o),
		.tag_len_o            (tag_len_o),
		.tag_valid_o          (tag_valid_o),
		.val_o                (val_o),
		.val_len_o            (val_len_o),
		.val_valid_o          (val_valid_o),
		.checksum_o           (checksum_o),
		.start_chksm_o        (start_chksm_o)
	);

endmodule

/* hw/msg_builder/field_encoder.sv */
// Field encoder for the FIX message builder.
// Decodes the requested field into a tag constant or a value source and
// registers it on emit, one cycle later the matching strobe goes out.

module field_encoder (
	input  logic                  clk,
	input  logic                  rst,
	fix_field_if.encoder          fld,
	input  logic                  bodylen_ready_i,
	input  logic                  seq_ready_i,
	input  fix_msg_pkg::value_t   body_len_i,
	input  fix_msg_pkg::val_len_t body_len_len_i,
	input  fix_msg_pkg::value_t   seq_num_i,
	input  fix_msg_pkg::val_len_t seq_num_len_i,
	input  fix_msg_pkg::value_t   sender_comp_id_i,
	input  fix_msg_pkg::val_len_t sender_comp_id_len_i,
	input  fix_msg_pkg::value_t   target_comp_id_i,
	input  fix_msg_pkg::val_len_t target_comp_id_len_i,
	input  fix_msg_pkg::value_t   send_time_i,
	input  fix_msg_pkg::val_len_t send_time_len_i,
	input  fix_msg_pkg::value_t   heartbeat_int_i,
	input  fix_msg_pkg::val_len_t heartbeat_int_len_i,
	output fix_tag_pkg::tag_t     tag_o,
	output fix_tag_pkg::tag_len_t tag_len_o,
	output logic                  tag_valid_o,
	output fix_msg_pkg::value_t   val_o,
	output fix_msg_pkg::val_len_t val_len_o,
	output logic                  val_valid_o,
	output logic                  checksum_o,
	output logic                  start_chksm_o
);
	import fix_msg_pkg::*;
	import fix_tag_pkg::*;

	tag_t     tag_sel;
	tag_len_t tag_len_sel;
	value_t   val_sel;
	val_len_t val_len_sel;

	// tag lookup
	always_comb begin
		case (fld.field_id)
			FLD_BEGIN_STRING:   {tag_sel, tag_len_sel} = {TAG_BEGIN_STRING, TAG_LEN_BEGIN_STRING};
			FLD_BODY_LENGTH:    {tag_sel, tag_len_sel} = {TAG_BODY_LENGTH, TAG_LEN_BODY_LENGTH};
			FLD_MSG_TYPE:       {tag_sel, tag_len_sel} = {TAG_MSG_TYPE, TAG_LEN_MSG_TYPE};
			FLD_MSG_SEQ_NUM:    {tag_sel, tag_len_sel} = {TAG_MSG_SEQ_NUM, TAG_LEN_MSG_SEQ_NUM};
			FLD_SENDER_COMP_ID: {tag_sel, tag_len_sel} = {TAG_SENDER_COMP_ID, TAG_LEN_SENDER_COMP_ID};
			FLD_SENDING_TIME:   {tag_sel, tag_len_sel} = {TAG_SENDING_TIME, TAG_LEN_SENDING_TIME};
			FLD_TARGET_COMP_ID: {tag_sel, tag_len_sel} = {TAG_TARGET_COMP_ID, TAG_LEN_TARGET_COMP_ID};
			FLD_ENCRYPT_METHOD: {tag_sel, tag_len_sel} = {TAG_ENCRYPT_METHOD, TAG_LEN_ENCRYPT_METHOD};
			FLD_HEARTBT_INT:    {tag_sel, tag_len_sel} = {TAG_HEARTBT_INT, TAG_LEN_HEARTBT_INT};
			FLD_CHECKSUM:       {tag_sel, tag_len_sel} = {TAG_CHECKSUM, TAG_LEN_CHECKSUM};
			default:            {tag_sel, tag_len_sel} = '0;
		endcase
	end

	// value source, CheckSum has none
	always_comb begin
		val_sel     = '0;
		val_len_sel = '0;
		case (fld.field_id)
			FLD_BEGIN_STRING: begin
				val_sel     = BEGIN_STRING_VAL;
				val_len_sel = BEGIN_STRING_LEN;
			end
			FLD_BODY_LENGTH:    {val_sel, val_len_sel} = {body_len_i, body_len_len_i};
			FLD_MSG_TYPE: begin
				val_len_sel = MSGTYPE_LEN;
				case (fld.msg_type)
					MSG_LOGON:     val_sel = MSGTYPE_LOGON_VAL;
					MSG_HEARTBEAT: val_sel = MSGTYPE_HEARTBEAT_VAL;
					MSG_LOGOUT:    val_sel = MSGTYPE_LOGOUT_VAL;
					default:       val_len_sel = '0;
				endcase
			end
			FLD_MSG_SEQ_NUM:    {val_sel, val_len_sel} = {seq_num_i, seq_num_len_i};
			FLD_SENDER_COMP_ID: {val_sel, val_len_sel} = {sender_comp_id_i, sender_comp_id_len_i};
			FLD_SENDING_TIME:   {val_sel, val_len_sel} = {send_time_i, send_time_len_i};
			FLD_TARGET_COMP_ID: {val_sel, val_len_sel} = {target_comp_id_i, target_comp_id_len_i};
			FLD_ENCRYPT_METHOD: begin
				val_sel     = ENCRYPT_METHOD_VAL;
				val_len_sel = ENCRYPT_METHOD_LEN;
			end
			FLD_HEARTBT_INT:    {val_sel, val_len_sel} = {heartbeat_int_i, heartbeat_int_len_i};
			default: begin
				val_sel     = '0;
				val_len_sel = '0;
			end
		endcase
	end

	// BodyLength and MsgSeqNum values come from producers that may lag
	assign fld.item_ready = !(fld.is_value &&
		((fld.field_id == FLD_BODY_LENGTH && !bodylen_ready_i) ||
		 (fld.field_id == FLD_MSG_SEQ_NUM && !seq_ready_i)));

	// strobes, one cycle after emit
	always_ff @(posedge clk) begin
		if (rst) begin
			tag_valid_o   <= 1'b0;
			val_valid_o   <= 1'b0;
			checksum_o    <= 1'b0;
			start_chksm_o <= 1'b0;
		end else begin
			tag_valid_o   <= fld.emit && !fld.is_value;
			val_valid_o   <= fld.emit && fld.is_value;
			checksum_o    <= fld.emit && !fld.is_value && fld.field_id == FLD_CHECKSUM;
			start_chksm_o <= fld.emit && fld.is_value && fld.field_id == FLD_BEGIN_STRING;
		end
	end

	// data holds its last item between strobes
	always_ff @(posedge clk) begin
		if (fld.emit && !fld.is_value) begin
			tag_o     <= tag_sel;
			tag_len_o <= tag_len_sel;
		end
		if (fld.emit && fld.is_value) begin
			val_o     <= val_sel;
			val_len_o <= val_len_sel;
		end
	end

endmodule

/* hw/msg_builder/field_sequencer.sv */
// FSM that steps through the fields of one FIX message.
// Each field gives a tag item and a value item (CheckSum gives only its tag),
// every item waits for done_i, and the message ends on end_i.

module field_sequencer (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start_i,
	input  fix_msg_pkg::msg_type_t msg_type_i,
	input  logic                   done_i,
	input  logic                   end_i,
	input  logic                   fifo_full_i,
	fix_field_if.sequencer         fld,
	output logic                   msg_done_o
);
	import fix_msg_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		// request pending, waiting for a free cycle
		ST_ISSUE,
		ST_WAIT_DONE,
		ST_WAIT_END
	} state_t;

	state_t    state;
	field_id_t field_q;
	field_id_t next_field;
	logic      is_value_q;
	msg_type_t type_q;
	logic      type_ok;
	logic      emit;

	// only the three session types start a message
	always_comb begin
		case (msg_type_i)
			MSG_LOGON,
			MSG_HEARTBEAT,
			MSG_LOGOUT: type_ok = 1'b1;
			default:    type_ok = 1'b0;
		endcase
	end

	// field after the current one
	// non-logon messages go straight from TargetCompID to CheckSum
	always_comb begin
		if (field_q == FLD_TARGET_COMP_ID && type_q != MSG_LOGON) begin
			next_field = FLD_CHECKSUM;
		end else begin
			next_field = field_id_t'(field_q + 4'd1);
		end
	end

	// a request goes out only when the FIFO has room and the value is there
	assign emit = (state == ST_ISSUE) && !fifo_full_i && fld.item_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= ST_IDLE;
			field_q    <= FLD_BEGIN_STRING;
			is_value_q <= 1'b0;
			type_q     <= MSG_LOGON;
			msg_done_o <= 1'b0;
		end else begin
			msg_done_o <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start_i && !fifo_full_i && type_ok) begin
						type_q     <= msg_type_i;
						field_q    <= FLD_BEGIN_STRING;
						is_value_q <= 1'b0;
						state      <= ST_ISSUE;
					end
				end
				ST_ISSUE: begin
					if (emit) begin
						// the CheckSum tag is the last item
						if (field_q == FLD_CHECKSUM) begin
							state <= ST_WAIT_END;
						end else begin
							state <= ST_WAIT_DONE;
						end
					end
				end
				ST_WAIT_DONE: begin
					if (done_i) begin
						if (!is_value_q) begin
							is_value_q <= 1'b1;
						end else begin
							is_value_q <= 1'b0;
							field_q    <= next_field;
						end
						state <= ST_ISSUE;
					end
				end
				ST_WAIT_END: begin
					// done_i is ignored here, the serializer closes with end_i
					if (end_i) begin
						msg_done_o <= 1'b1;
						state      <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	assign fld.emit     = emit;
	assign fld.field_id = field_q;
	assign fld.is_value = is_value_q;
	assign fld.msg_type = type_q;

endmodule

/* common/fix_field_if.sv */
// Field request between the field sequencer and the field encoder.
// The sequencer names one item (tag or value of a field) and strobes emit,
// the encoder answers with item_ready for values that are gated.

interface fix_field_if;
	import fix_msg_pkg::*;

	// one-cycle request for the item named below
	logic      emit;
	field_id_t field_id;
	// low selects the tag, high the value
	logic      is_value;
	msg_type_t msg_type;
	// low while a gated value is not yet available
	logic      item_ready;

	modport sequencer (
		output emit,
		output field_id,
		output is_value,
		output msg_type,
		input  item_ready
	);

	modport encoder (
		input  emit,
		input  field_id,
		input  is_value,
		input  msg_type,
		output item_ready
	);

endinterface

/* common/fix_tag_pkg.sv */
// Wire-format constants for the FIX message builder.
// Tag strings include the trailing '=' and are left-aligned in one word,
// fixed values are left-aligned in a value word like the input values.

package fix_tag_pkg;

	localparam int TAG_BYTES = 4;
	localparam int TAG_LEN_W = 3;

	typedef logic [TAG_BYTES*8-1:0] tag_t;
	typedef logic [TAG_LEN_W-1:0]   tag_len_t;

	// header fields
	localparam tag_t     TAG_BEGIN_STRING       = {"8=", 16'h0000};
	localparam tag_len_t TAG_LEN_BEGIN_STRING   = 3'd2;
	localparam tag_t     TAG_BODY_LENGTH        = {"9=", 16'h0000};
	localparam tag_len_t TAG_LEN_BODY_LENGTH    = 3'd2;
	localparam tag_t     TAG_MSG_TYPE           = {"35=", 8'h00};
	localparam tag_len_t TAG_LEN_MSG_TYPE       = 3'd3;
	localparam tag_t     TAG_MSG_SEQ_NUM        = {"34=", 8'h00};
	localparam tag_len_t TAG_LEN_MSG_SEQ_NUM    = 3'd3;
	localparam tag_t     TAG_SENDER_COMP_ID     = {"49=", 8'h00};
	localparam tag_len_t TAG_LEN_SENDER_COMP_ID = 3'd3;
	localparam tag_t     TAG_SENDING_TIME       = {"52=", 8'h00};
	localparam tag_len_t TAG_LEN_SENDING_TIME   = 3'd3;
	localparam tag_t     TAG_TARGET_COMP_ID     = {"56=", 8'h00};
	localparam tag_len_t TAG_LEN_TARGET_COMP_ID = 3'd3;

	// logon body
	localparam tag_t     TAG_ENCRYPT_METHOD     = {"98=", 8'h00};
	localparam tag_len_t TAG_LEN_ENCRYPT_METHOD = 3'd3;
	localparam tag_t     TAG_HEARTBT_INT        = "108=";
	localparam tag_len_t TAG_LEN_HEARTBT_INT    = 3'd4;

	// trailer
	localparam tag_t     TAG_CHECKSUM           = {"10=", 8'h00};
	localparam tag_len_t TAG_LEN_CHECKSUM       = 3'd3;

	// protocol version string
	localparam fix_msg_pkg::value_t   BEGIN_STRING_VAL   = {"FIX.4.2", 8'h00};
	localparam fix_msg_pkg::val_len_t BEGIN_STRING_LEN   = 4'd7;

	// no encryption
	localparam fix_msg_pkg::value_t   ENCRYPT_METHOD_VAL = {"0", 56'h0};
	localparam fix_msg_pkg::val_len_t ENCRYPT_METHOD_LEN = 4'd1;

	// MsgType codes, all single characters
	localparam fix_msg_pkg::value_t   MSGTYPE_LOGON_VAL     = {"A", 56'h0};
	localparam fix_msg_pkg::value_t   MSGTYPE_HEARTBEAT_VAL = {"0", 56'h0};
	localparam fix_msg_pkg::value_t   MSGTYPE_LOGOUT_VAL    = {"5", 56'h0};
	localparam fix_msg_pkg::val_len_t MSGTYPE_LEN           = 4'd1;

endpackage

/* common/fix_msg_pkg.sv */
// Message-level definitions for the FIX session message builder.
// Value width, value length, message type codes and the field order
// are shared by the sequencer, the encoder and the testbench model.

package fix_msg_pkg;

	// one value word holds up to eight ASCII characters
	localparam int VALUE_BYTES = 8;
	localparam int VALUE_W     = VALUE_BYTES * 8;
	localparam int VAL_LEN_W   = 4;

	// first character sits in the top byte, unused bytes are zero
	typedef logic [VALUE_W-1:0] value_t;

	// count of valid bytes, 0 to VALUE_BYTES
	typedef logic [VAL_LEN_W-1:0] val_len_t;

	// one-hot style codes, any other value is rejected at start
	typedef enum logic [3:0] {
		MSG_LOGON     = 4'd1,
		MSG_HEARTBEAT = 4'd2,
		MSG_LOGOUT    = 4'd4
	} msg_type_t;

	// fields in the order they go out on the wire
	typedef enum logic [3:0] {
		FLD_BEGIN_STRING   = 4'd0,
		FLD_BODY_LENGTH    = 4'd1,
		FLD_MSG_TYPE       = 4'd2,
		FLD_MSG_SEQ_NUM    = 4'd3,
		FLD_SENDER_COMP_ID = 4'd4,
		FLD_SENDING_TIME   = 4'd5,
		FLD_TARGET_COMP_ID = 4'd6,
		// logon only
		FLD_ENCRYPT_METHOD = 4'd7,
		FLD_HEARTBT_INT    = 4'd8,
		// tag only, the serializer fills in the sum
		FLD_CHECKSUM       = 4'd9
	} field_id_t;

endpackage
